// ==== verilog/uart_pkg.sv ====
package uart_pkg;

    // Serial bit period counted in clk_50M cycles
    localparam int bit_cycles = 16;
    localparam int bit_cnt_w  = $clog2(bit_cycles);
    localparam int data_bits  = 8;                      // 8N1 framing

    typedef logic [bit_cnt_w-1:0] bit_cnt_t;
    typedef logic [data_bits-1:0] byte_t;
    typedef logic [2:0]           bit_idx_t;            // Index of the data bit

    // Counter end values for a full period and for half a period
    localparam bit_cnt_t bit_last  = bit_cnt_t'(bit_cycles - 1);
    localparam bit_cnt_t half_last = bit_cnt_t'(bit_cycles / 2 - 1);
    localparam bit_idx_t idx_last  = bit_idx_t'(data_bits - 1);

    typedef enum logic [1:0] {
        rx_idle,                                        // Line high, waiting for start edge
        rx_start,                                       // Checking start bit at mid-bit
        rx_data,                                        // Shifting in data bits
        rx_stop                                         // Stop bit check
    } rx_state_t;

endpackage

// ==== verilog/sram_pkg.sv ====
package sram_pkg;

    // BaseRAM geometry
    localparam int sram_addr_w    = 20;
    localparam int sram_data_w    = 32;
    localparam int bytes_per_word = sram_data_w / 8;

    typedef logic [sram_addr_w-1:0]            sram_addr_t;
    typedef logic [sram_data_w-1:0]            sram_data_t;
    typedef logic [$clog2(bytes_per_word)-1:0] byte_idx_t;

    localparam byte_idx_t last_byte = byte_idx_t'(bytes_per_word - 1);

    // Width of the write strobe in clk_50M cycles
    localparam int write_cycles = 3;
    typedef logic [$clog2(write_cycles)-1:0] we_cnt_t;
    localparam we_cnt_t write_last = we_cnt_t'(write_cycles - 1);

    // Byte FIFO between receiver and loader
    localparam int fifo_depth = 16;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
    typedef logic [fifo_ptr_w:0]   fifo_cnt_t;          // One extra bit for full
    localparam fifo_cnt_t fifo_full_count = fifo_cnt_t'(fifo_depth);

    localparam int led_w = 16;
    typedef logic [led_w-1:0] led_t;

    typedef enum logic [1:0] {
        ld_collect,                                     // Gathering bytes from FIFO
        ld_setup,                                       // CE low, bus driven
        ld_strobe,                                      // WE low
        ld_recover                                      // WE high, CE still low
    } loader_state_t;

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx
    import uart_pkg::*;
(
    input  logic  clk_50M,
    input  logic  reset,
    input  logic  rxd,
    output byte_t rx_byte,
    output logic  byte_valid
);

    logic      rxd_meta;
    logic      rxd_sync;
    rx_state_t state;
    bit_cnt_t  bit_cnt;
    bit_idx_t  bit_idx;
    byte_t     shift_reg;
    logic      frame_bad;                               // Stop bit sampled low

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk_50M) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk_50M) begin
        if (reset) begin
            state      <= rx_idle;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            frame_bad  <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    bit_cnt <= '0;
                    if (!rxd_sync)
                        state <= rx_start;              // Falling edge seen
                end
                rx_start: begin
                    if (bit_cnt == half_last) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // A line back high at mid start bit was only a glitch
                        state   <= rxd_sync ? rx_idle : rx_data;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_cnt == bit_last) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == idx_last)
                            state <= rx_stop;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (frame_bad) begin
                        if (rxd_sync) begin             // Line recovered
                            frame_bad <= 1'b0;
                            state     <= rx_idle;
                        end
                    end else if (bit_cnt == bit_last) begin
                        bit_cnt <= '0;
                        if (rxd_sync) begin
                            byte_valid <= 1'b1;
                            state      <= rx_idle;
                        end else begin
                            frame_bad <= 1'b1;          // Framing error, drop byte
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk_50M) begin
        if (state == rx_data && bit_cnt == bit_last)
            shift_reg <= {rxd_sync, shift_reg[data_bits-1:1]};
        if (state == rx_stop && !frame_bad && bit_cnt == bit_last)
            rx_byte <= shift_reg;
    end

endmodule

// ==== verilog/byte_fifo.sv ====
`timescale 1ns/100ps

module byte_fifo
    import uart_pkg::*;
    import sram_pkg::*;
(
    input  logic  clk_50M,
    input  logic  reset,
    input  logic  push,
    input  byte_t push_byte,
    input  logic  pop,
    output byte_t fifo_byte,
    output logic  fifo_empty,
    output logic  overflow
);

    byte_t     mem [fifo_depth];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      full;
    logic      do_push;
    logic      do_pop;

    assign full       = (count == fifo_full_count);
    assign fifo_empty = (count == '0);
    assign do_push    = push && !full;                  // Push on full is dropped
    assign do_pop     = pop && !fifo_empty;
    assign fifo_byte  = mem[rd_ptr];                    // Head of queue

    always_ff @(posedge clk_50M) begin
        if (do_push)
            mem[wr_ptr] <= push_byte;
    end

    always_ff @(posedge clk_50M) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;                // Wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Both or neither
            endcase
            if (push && full)
                overflow <= 1'b1;                       // Sticky until reset
        end
    end

endmodule

// ==== verilog/sram_loader.sv ====
`timescale 1ns/100ps

module sram_loader
    import uart_pkg::*;
    import sram_pkg::*;
(
    input  logic       clk_50M,
    input  logic       reset,
    input  logic       hold,
    input  byte_t      fifo_byte,
    input  logic       fifo_empty,
    output logic       pop,
    output sram_addr_t base_ram_addr,
    output sram_data_t write_data,
    output logic       data_drive,
    output logic       base_ram_ce_n,
    output logic       base_ram_we_n,
    output sram_addr_t word_count
);

    loader_state_t state;
    byte_idx_t     byte_idx;                            // Next byte lane to fill
    we_cnt_t       we_cnt;
    sram_addr_t    word_addr;

    // Hold only stops new pops, a write already started runs to the end
    assign pop = (state == ld_collect) && !fifo_empty && !hold;

    // Words are stored from address zero up, so the address is also the count
    assign base_ram_addr = word_addr;
    assign word_count    = word_addr;

    // Little-endian packing, first byte ends in bits 7:0
    always_ff @(posedge clk_50M) begin
        if (pop)
            write_data <= {fifo_byte, write_data[sram_data_w-1:data_bits]};
    end

    always_ff @(posedge clk_50M) begin
        if (reset) begin
            state         <= ld_collect;
            byte_idx      <= '0;
            we_cnt        <= '0;
            word_addr     <= '0;
            data_drive    <= 1'b0;
            base_ram_ce_n <= 1'b1;
            base_ram_we_n <= 1'b1;
        end else begin
            case (state)
                ld_collect: begin
                    if (pop) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == last_byte) begin
                            state         <= ld_setup;
                            base_ram_ce_n <= 1'b0;  // Select chip, drive bus
                            data_drive    <= 1'b1;
                        end
                    end
                end
                ld_setup: begin
                    state         <= ld_strobe;
                    we_cnt        <= '0;
                    base_ram_we_n <= 1'b0;          // Address settled, start write
                end
                ld_strobe: begin
                    if (we_cnt == write_last) begin
                        state         <= ld_recover;
                        base_ram_we_n <= 1'b1;      // Data latched on this edge
                    end else begin
                        we_cnt <= we_cnt + 1'b1;
                    end
                end
                ld_recover: begin
                    state         <= ld_collect;
                    base_ram_ce_n <= 1'b1;
                    data_drive    <= 1'b0;
                    word_addr     <= word_addr + 1'b1;
                end
                default: state <= ld_collect;
            endcase
        end
    end

endmodule

// ==== verilog/thinpad_top.sv ====
`timescale 1ns/100ps

module thinpad_top
    import uart_pkg::*;
    import sram_pkg::*;
(
    input  wire              clk_50M,
    input  wire              reset,
    input  wire [3:0]        touch_btn,                 // Bit 0 holds the loader
    input  wire              rxd,
    inout  wire sram_data_t  base_ram_data,
    output sram_addr_t       base_ram_addr,
    output logic [3:0]       base_ram_be_n,
    output logic             base_ram_ce_n,
    output logic             base_ram_oe_n,
    output logic             base_ram_we_n,
    output led_t             leds
);

    byte_t      rx_byte;
    logic       byte_valid;
    byte_t      fifo_byte;
    logic       fifo_empty;
    logic       overflow;
    logic       pop;
    sram_data_t write_data;
    logic       data_drive;
    sram_addr_t word_count;

    uart_rx u_uart_rx (
        .clk_50M    (clk_50M),
        .reset      (reset),
        .rxd        (rxd),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid)
    );

    byte_fifo u_byte_fifo (
        .clk_50M    (clk_50M),
        .reset      (reset),
        .push       (byte_valid),
        .push_byte  (rx_byte),
        .pop        (pop),
        .fifo_byte  (fifo_byte),
        .fifo_empty (fifo_empty),
        .overflow   (overflow)
    );

    sram_loader u_sram_loader (
        .clk_50M       (clk_50M),
        .reset         (reset),
        .hold          (touch_btn[0]),
        .fifo_byte     (fifo_byte),
        .fifo_empty    (fifo_empty),
        .pop           (pop),
        .base_ram_addr (base_ram_addr),
        .write_data    (write_data),
        .data_drive    (data_drive),
        .base_ram_ce_n (base_ram_ce_n),
        .base_ram_we_n (base_ram_we_n),
        .word_count    (word_count)
    );

    assign base_ram_data = data_drive ? write_data : 'z;   // Released outside writes
    assign base_ram_oe_n = 1'b1;                            // Write only
    assign base_ram_be_n = 4'b0000;                         // All byte lanes
    assign leds          = {overflow, word_count[led_w-2:0]};

endmodule

// ==== bench/loader_properties.sv ====
`timescale 1ns/100ps

module loader_properties
    import sram_pkg::*;
(
    input logic       clk_50M,
    input logic       reset,
    input logic       hold,
    input logic       fifo_empty,
    input logic       pop,
    input sram_addr_t base_ram_addr,
    input sram_data_t write_data,
    input logic       data_drive,
    input logic       base_ram_ce_n,
    input logic       base_ram_we_n
);

    we_needs_select: assert property (@(posedge clk_50M) disable iff (reset)
        !base_ram_we_n |-> !base_ram_ce_n && data_drive)
        else $error("Write strobe low without chip select and bus drive");

    // Values are already final in the setup cycle before the strobe
    bus_stable: assert property (@(posedge clk_50M) disable iff (reset)
        !base_ram_we_n |-> $stable(base_ram_addr) && $stable(write_data))
        else $error("Address or data changed during the write strobe");

    we_width: assert property (@(posedge clk_50M) disable iff (reset)
        $fell(base_ram_we_n) |-> !base_ram_we_n [*write_cycles] ##1 base_ram_we_n)
        else $error("Write strobe low for the wrong number of cycles");

    // No byte is taken while a write owns the bus
    pop_allowed: assert property (@(posedge clk_50M) disable iff (reset)
        pop |-> !fifo_empty && !hold && base_ram_ce_n)
        else $error("Pop while the FIFO is empty, the loader is held or a write is active");

endmodule

bind sram_loader loader_properties u_loader_properties (
    .clk_50M       (clk_50M),
    .reset         (reset),
    .hold          (hold),
    .fifo_empty    (fifo_empty),
    .pop           (pop),
    .base_ram_addr (base_ram_addr),
    .write_data    (write_data),
    .data_drive    (data_drive),
    .base_ram_ce_n (base_ram_ce_n),
    .base_ram_we_n (base_ram_we_n)
);

// ==== bench/thinpad_tb.sv ====
`timescale 1ns/100ps

module thinpad_tb
    import uart_pkg::*;
    import sram_pkg::*;
();

    localparam int wait_limit = 1000;                   // Cycles per wait

    logic       clk_50M = 1'b0;
    logic       reset;
    logic [3:0] touch_btn;
    logic       rxd;
    wire        sram_data_t base_ram_data;
    sram_addr_t base_ram_addr;
    logic [3:0] base_ram_be_n;
    logic       base_ram_ce_n;
    logic       base_ram_oe_n;
    logic       base_ram_we_n;
    led_t       leds;
    sram_addr_t got_addr [$];                           // Writes seen on the bus
    sram_data_t got_data [$];
    logic [3:0] got_be_n [$];
    logic [7:0] lfsr;

    thinpad_top dut (
        .clk_50M       (clk_50M),
        .reset         (reset),
        .touch_btn     (touch_btn),
        .rxd           (rxd),
        .base_ram_data (base_ram_data),
        .base_ram_addr (base_ram_addr),
        .base_ram_be_n (base_ram_be_n),
        .base_ram_ce_n (base_ram_ce_n),
        .base_ram_oe_n (base_ram_oe_n),
        .base_ram_we_n (base_ram_we_n),
        .leds          (leds)
    );

    always #2 clk_50M = ~clk_50M;                       // 4 ns period

    // SRAM latches on the rising edge of WE
    always @(posedge base_ram_we_n) begin
        if (!reset) begin
            got_addr.push_back(base_ram_addr);
            got_data.push_back(base_ram_data);
            got_be_n.push_back(base_ram_be_n);
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        if (s[0])
            return (s >> 1) ^ 8'hb8;                    // Galois taps 8,6,5,4
        else
            return s >> 1;
    endfunction

    task automatic drive_bit(input logic b);
        repeat (bit_cycles) begin
            @(posedge clk_50M);
            rxd <= b;
        end
    endtask

    task automatic send_frame(input byte_t data, input logic stop);
        int gap;
        gap = 0;
        for (int i = 0; i < 3; i++) begin
            gap = gap | (int'(lfsr[0]) << i);
            lfsr = lfsr_step(lfsr);
        end
        repeat (gap)
            drive_bit(1'b1);                            // Idle gap in bit periods
        drive_bit(1'b0);
        for (int i = 0; i < data_bits; i++)
            drive_bit(data[i]);
        drive_bit(stop);
        if (!stop)
            drive_bit(1'b1);                            // Line recovers after a bad stop bit
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(negedge clk_50M);
            n++;
            if (n > wait_limit)
                fail_now("Timeout waiting for the receiver and loader to go idle");
        end while (!(dut.u_uart_rx.state == rx_idle && dut.u_sram_loader.state == ld_collect
                     && (dut.u_byte_fifo.fifo_empty || touch_btn[0])));
    endtask

    task automatic check_write(input sram_addr_t exp_addr, input sram_data_t exp_data);
        int         n;
        sram_addr_t addr;
        sram_data_t data;
        logic [3:0] be_n;
        n = 0;
        while (got_addr.size() == 0) begin
            @(negedge clk_50M);
            n++;
            if (n > wait_limit)
                fail_now($sformatf("Timeout waiting for the write to address %h", exp_addr));
        end
        addr = got_addr.pop_front();
        data = got_data.pop_front();
        be_n = got_be_n.pop_front();
        if (addr !== exp_addr || data !== exp_data)
            fail_now($sformatf("ERROR at %0t: write %h <= %h, expected %h <= %h",
                               $time, addr, data, exp_addr, exp_data));
        if (be_n !== 4'b0000)
            fail_now($sformatf("ERROR at %0t: base_ram_be_n reads %b in a write, expected 0000",
                               $time, be_n));
    endtask

    task automatic check_leds(input led_t exp);
        wait_idle();
        if (got_addr.size() != 0)
            fail_now($sformatf("A write to address %h happened that was not expected",
                               got_addr[0]));
        if (leds !== exp)
            fail_now($sformatf("ERROR at %0t: leds read %h, expected %h", $time, leds, exp));
    endtask

    task automatic check_high(input string name, input logic got);
        if (got !== 1'b1)
            fail_now($sformatf("ERROR at %0t: %s reads %b after reset, expected 1",
                               $time, name, got));
    endtask

    initial begin
        string       line;
        int          fd;
        logic [7:0]  cmd;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        reset     = 1'b1;
        touch_btn = '0;
        rxd       = 1'b1;
        lfsr      = 8'd73;
        repeat (3) @(posedge clk_50M);
        reset <= 1'b0;
        @(negedge clk_50M);
        check_high("base_ram_we_n", base_ram_we_n);
        check_high("base_ram_ce_n", base_ram_ce_n);
        check_high("base_ram_oe_n", base_ram_oe_n);
        check_leds('0);
        fd = $fopen("bench/loader_stimulus.txt", "r");
        if (fd == 0)
            fail_now("Could not open the stimulus file bench/loader_stimulus.txt");
        while (!$feof(fd)) begin
            line = "";
            cmd  = "#";
            void'($fgets(line, fd));
            void'($sscanf(line, "%c %h %h", cmd, arg_a, arg_b));
            case (cmd)
                "B": for (int i = 0; i < arg_a; i++)
                         send_frame(byte_t'(arg_b + i), 1'b1);  // Rising byte values
                "F": send_frame(byte_t'(arg_a), 1'b0);
                "H": begin
                    @(posedge clk_50M);
                    touch_btn[0] <= arg_a[0];
                end
                "E": check_write(sram_addr_t'(arg_a), sram_data_t'(arg_b));
                "L": check_leds(led_t'(arg_a));
                "#", "\n", "\r", " ": ;                 // Comment or blank line
                default: fail_now($sformatf("Unknown command in stimulus line: %s", line));
            endcase
        end
        $fclose(fd);
        wait_idle();
        if (got_addr.size() != 0)
            fail_now("The loader made more writes than the stimulus file expects");
        else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== bench/loader_stimulus.txt ====
# B count first_byte: good frames of rising bytes | F byte: frame with low stop bit
# H level: touch_btn[0] | E addr data: expected write | L value: leds once idle
B 08 11
E 00000 14131211
E 00001 18171615
L 0002
B 01 a0
F ff
B 03 a1
E 00002 a3a2a1a0
B 03 c0
L 0003
B 01 c3
E 00003 c3c2c1c0
L 0004
H 1
B 0c d0
L 0004
H 0
E 00004 d3d2d1d0
E 00005 d7d6d5d4
E 00006 dbdad9d8
L 0007
H 1
B 14 e0
L 8007
H 0
E 00007 e3e2e1e0
E 00008 e7e6e5e4
E 00009 ebeae9e8
E 0000a efeeedec
L 800b

// ==== list.f ====
verilog/uart_pkg.sv
verilog/sram_pkg.sv
verilog/uart_rx.sv
verilog/byte_fifo.sv
verilog/sram_loader.sv
verilog/thinpad_top.sv
bench/loader_properties.sv
bench/thinpad_tb.sv

// ==== Bender.yml ====
package:
  name: thinpad_loader

sources:
  - verilog/uart_pkg.sv
  - verilog/sram_pkg.sv
  - verilog/uart_rx.sv
  - verilog/byte_fifo.sv
  - verilog/sram_loader.sv
  - verilog/thinpad_top.sv
  - target: simulation
    files:
      - bench/loader_properties.sv
      - bench/thinpad_tb.sv
